//--- list.f
rtl/rob_pkg.sv
rtl/tag_pkg.sv
rtl/rob_pointers.sv
rtl/rob_entries.sv
rtl/rob_read_port.sv
rtl/reorder_buffer.sv
tests/reorder_buffer_sva.sv
tests/tb_reorder_buffer.sv

//--- run.sh
#!/usr/bin/env bash
# Build the reorder buffer testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f list.f \
    --top-module tb_reorder_buffer \
    -Mdir obj_dir -o sim_reorder_buffer

./obj_dir/sim_reorder_buffer

//--- tests/tb_reorder_buffer.sv
module tb_reorder_buffer;
    timeunit 1ns;
    timeprecision 100ps;

    logic                clk   = 1'b0;
    logic                reset = 1'b0;
    logic [1:0]          alloc_en;
    tag_pkg::tag_t       alloc_tag_0;
    tag_pkg::tag_t       alloc_tag_1;
    rob_pkg::dest_t      alloc_dest_0;
    rob_pkg::dest_t      alloc_dest_1;
    logic                alloc_ok;
    logic [1:0]          cdb_valid;
    rob_pkg::rob_idx_t   cdb_idx_0;
    rob_pkg::rob_idx_t   cdb_idx_1;
    rob_pkg::rob_data_t  cdb_data_0;
    rob_pkg::rob_data_t  cdb_data_1;
    logic [1:0]          cdb_exc;
    rob_pkg::rob_idx_t   rd_idx_0;
    rob_pkg::rob_idx_t   rd_idx_1;
    rob_pkg::rob_data_t  rd_data_0;
    rob_pkg::rob_data_t  rd_data_1;
    tag_pkg::tag_t       rd_tag_0;
    tag_pkg::tag_t       rd_tag_1;
    logic                commit_ready_0;
    logic                commit_ready_1;
    rob_pkg::rob_data_t  commit_data_0;
    rob_pkg::rob_data_t  commit_data_1;
    rob_pkg::dest_t      commit_dest_0;
    rob_pkg::dest_t      commit_dest_1;
    logic                commit_exc_0;
    logic                commit_exc_1;
    rob_pkg::rob_count_t count;
    logic                empty;
    logic                full;
    rob_pkg::rob_idx_t   head_idx;
    rob_pkg::rob_idx_t   tail_idx;

    logic [31:0]         lfsr = 32'd88770;
    int                  mode;   // 0 idle, 1 fill, 2 random traffic
    int                  cycle;

    // Reference model with pointers that count up without wrapping
    int                  m_head;
    int                  m_tail;
    rob_pkg::rob_data_t  m_data [rob_pkg::rob_depth];
    tag_pkg::tag_t       m_tag  [rob_pkg::rob_depth];
    rob_pkg::dest_t      m_dest [rob_pkg::rob_depth];
    logic                m_exec [rob_pkg::rob_depth];
    logic                m_exc  [rob_pkg::rob_depth];

    reorder_buffer uut (.*);

    initial begin
        forever #2 clk = ~clk;
    end

    // ============================================================
    // Random source and helpers
    // ============================================================
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            val  = {val[30:0], lfsr[0]};
        end
        return val;
    endfunction

    function automatic rob_pkg::rob_idx_t wrap_idx(input int ptr);
        return rob_pkg::rob_idx_t'(ptr % rob_pkg::rob_depth);
    endfunction

    // Mostly a live entry and now and then any entry
    function automatic rob_pkg::rob_idx_t pick_target(input int cnt);
        int off;
        off = int'(take_bits(4));
        if (cnt == 0 || take_bits(3) == 0) begin
            return rob_pkg::rob_idx_t'(off);
        end
        return wrap_idx(m_head + off % cnt);
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR: %s is 0x%h, expected 0x%h", name, got, exp);
            $display("STATUS: FAIL");
            $fatal(1, "output mismatch");
        end
    endtask

    task automatic clear_entry(input int i);
        m_data[i] = '0;
        m_tag[i]  = tag_pkg::tag_free;
        m_dest[i] = '0;
        m_exec[i] = 1'b0;
        m_exc[i]  = 1'b0;
    endtask

    // ============================================================
    // Stimulus
    // ============================================================
    task automatic drive_stimulus(input logic fill);
        int                cnt;
        logic [1:0]        en;
        rob_pkg::rob_idx_t c0;
        rob_pkg::rob_idx_t c1;
        logic [1:0]        sel;
        cnt = m_tail - m_head;
        if (fill) begin
            en = 2'b11;
        end else if ((cycle % 500) < 250) begin
            en = {take_bits(2) != 0, take_bits(2) != 0};  // Heavy allocation window
        end else begin
            en = {take_bits(3) == 0, take_bits(3) == 0};  // Drain window
        end
        c0 = pick_target(cnt);
        c1 = pick_target(cnt);
        alloc_en     <= en;
        alloc_tag_0  <= tag_pkg::tag_t'(take_bits(1));
        alloc_tag_1  <= tag_pkg::tag_t'(take_bits(1));
        alloc_dest_0 <= rob_pkg::dest_t'(take_bits(5));
        alloc_dest_1 <= rob_pkg::dest_t'(take_bits(5));
        cdb_valid    <= fill ? 2'b00 : 2'(take_bits(2));
        cdb_idx_0    <= c0;
        cdb_idx_1    <= c1;
        cdb_data_0   <= take_bits(32);
        cdb_data_1   <= take_bits(32);
        cdb_exc      <= {take_bits(2) == 0, take_bits(2) == 0};
        // Aim the read ports at the CDB targets or the tail now and then
        sel = 2'(take_bits(2));
        rd_idx_0 <= (sel == 2'd0) ? c0 : (sel == 2'd1) ? c1
                  : (sel == 2'd2) ? wrap_idx(m_tail) : rob_pkg::rob_idx_t'(take_bits(4));
        sel = 2'(take_bits(2));
        rd_idx_1 <= (sel == 2'd0) ? c1 : (sel == 2'd1) ? c0
                  : (sel == 2'd2) ? wrap_idx(m_tail + 1) : rob_pkg::rob_idx_t'(take_bits(4));
    endtask

    always @(posedge clk) begin
        if (mode != 0) begin
            drive_stimulus(mode == 1);
        end
    end

    // ============================================================
    // Checking against the model
    // ============================================================
    function automatic logic [34:0] expect_read(input rob_pkg::rob_idx_t idx,
                                                input logic [1:0] hit, input logic ok,
                                                input rob_pkg::rob_idx_t a0,
                                                input rob_pkg::rob_idx_t a1);
        if (hit[1] && cdb_idx_1 == idx) return {tag_pkg::tag_ready, cdb_data_1};
        if (hit[0] && cdb_idx_0 == idx) return {tag_pkg::tag_ready, cdb_data_0};
        if (ok && alloc_en[1] && a1 == idx) return {alloc_tag_1, 32'h0};
        if (ok && alloc_en[0] && a0 == idx) return {alloc_tag_0, 32'h0};
        return {m_tag[idx], m_data[idx]};
    endfunction

    task automatic check_cycle();
        int                cnt;
        int                n_alloc;
        logic              ok;
        logic [1:0]        hit;
        logic              rdy_0;
        logic              rdy_1;
        rob_pkg::rob_idx_t h0;
        rob_pkg::rob_idx_t h1;
        rob_pkg::rob_idx_t a0;
        rob_pkg::rob_idx_t a1;
        logic [34:0]       rd_0;
        logic [34:0]       rd_1;
        cnt     = m_tail - m_head;
        n_alloc = int'(alloc_en[0]) + int'(alloc_en[1]);
        ok      = (rob_pkg::rob_depth - cnt) >= n_alloc;   // All or nothing
        h0      = wrap_idx(m_head);
        h1      = wrap_idx(m_head + 1);
        a0      = wrap_idx(m_tail);
        a1      = alloc_en[0] ? wrap_idx(m_tail + 1) : a0;
        hit[0]  = cdb_valid[0] && m_tag[cdb_idx_0] == tag_pkg::tag_t'(0);
        hit[1]  = cdb_valid[1] && m_tag[cdb_idx_1] == tag_pkg::tag_t'(1);
        rdy_0   = cnt > 0 && m_exec[h0];
        rdy_1   = rdy_0 && cnt >= 2 && m_exec[h1];
        rd_0    = expect_read(rd_idx_0, hit, ok, a0, a1);
        rd_1    = expect_read(rd_idx_1, hit, ok, a0, a1);

        check_value("alloc_ok", 32'(alloc_ok), 32'(ok));
        check_value("count", 32'(count), 32'(cnt));
        check_value("empty", 32'(empty), 32'(cnt == 0));
        check_value("full", 32'(full), 32'(cnt == rob_pkg::rob_depth));
        check_value("head_idx", 32'(head_idx), 32'(h0));
        check_value("tail_idx", 32'(tail_idx), 32'(a0));
        check_value("commit_ready_0", 32'(commit_ready_0), 32'(rdy_0));
        check_value("commit_ready_1", 32'(commit_ready_1), 32'(rdy_1));
        check_value("commit_data_0", commit_data_0, m_data[h0]);
        check_value("commit_data_1", commit_data_1, m_data[h1]);
        check_value("commit_dest_0", 32'(commit_dest_0), 32'(m_dest[h0]));
        check_value("commit_dest_1", 32'(commit_dest_1), 32'(m_dest[h1]));
        check_value("commit_exc_0", 32'(commit_exc_0), 32'(m_exc[h0]));
        check_value("commit_exc_1", 32'(commit_exc_1), 32'(m_exc[h1]));
        check_value("rd_data_0", rd_data_0, rd_0[31:0]);
        check_value("rd_data_1", rd_data_1, rd_1[31:0]);
        check_value("rd_tag_0", 32'(rd_tag_0), 32'(rd_0[34:32]));
        check_value("rd_tag_1", 32'(rd_tag_1), 32'(rd_1[34:32]));

        if (reset) begin
            if (ok) begin
                if (alloc_en[0]) begin
                    m_data[a0] = '0;
                    m_tag[a0]  = alloc_tag_0;
                    m_dest[a0] = alloc_dest_0;
                    m_exec[a0] = 1'b0;
                    m_exc[a0]  = 1'b0;
                end
                if (alloc_en[1]) begin
                    m_data[a1] = '0;
                    m_tag[a1]  = alloc_tag_1;
                    m_dest[a1] = alloc_dest_1;
                    m_exec[a1] = 1'b0;
                    m_exc[a1]  = 1'b0;
                end
                m_tail = m_tail + n_alloc;
            end
            for (int k = 0; k < 2; k++) begin
                if (hit[k]) begin
                    m_data[k == 0 ? cdb_idx_0 : cdb_idx_1] = k == 0 ? cdb_data_0 : cdb_data_1;
                    m_tag[k == 0 ? cdb_idx_0 : cdb_idx_1]  = tag_pkg::tag_ready;
                    m_exec[k == 0 ? cdb_idx_0 : cdb_idx_1] = 1'b1;
                    m_exc[k == 0 ? cdb_idx_0 : cdb_idx_1]  = cdb_exc[k];
                end
            end
            if (rdy_0) clear_entry(int'(h0));
            if (rdy_1) clear_entry(int'(h1));
            m_head = m_head + int'(rdy_0) + int'(rdy_1);
        end
    endtask

    always @(negedge clk) begin
        if (!reset) begin
            m_head = 0;
            m_tail = 0;
            for (int i = 0; i < rob_pkg::rob_depth; i++) begin
                clear_entry(i);
            end
        end
        check_cycle();
        cycle = cycle + 1;
    end

    // ============================================================
    // Run control
    // ============================================================
    task automatic wait_for_full();
        int waited;
        waited = 0;
        while (!full && waited < 40) begin
            @(negedge clk);
            waited = waited + 1;
        end
        if (!full) begin
            $display("Timeout: the buffer never became full while allocating every cycle");
            $display("STATUS: FAIL");
            $fatal(1, "fill timeout");
        end
    endtask

    initial begin
        mode  = 0;
        cycle = 0;
        alloc_en     <= '0;
        alloc_tag_0  <= '0;
        alloc_tag_1  <= '0;
        alloc_dest_0 <= '0;
        alloc_dest_1 <= '0;
        cdb_valid    <= '0;
        cdb_idx_0    <= '0;
        cdb_idx_1    <= '0;
        cdb_data_0   <= '0;
        cdb_data_1   <= '0;
        cdb_exc      <= '0;
        rd_idx_0     <= '0;
        rd_idx_1     <= '0;
        repeat (3) @(posedge clk);
        reset <= 1'b1;
        @(negedge clk);
        mode = 1;          // Both slots every cycle, no results
        wait_for_full();
        mode = 2;
        repeat (3000) @(negedge clk);
        @(posedge clk);
        $display("STATUS: PASS");
        $finish;
    end

endmodule

//--- tests/reorder_buffer_sva.sv
module reorder_buffer_sva (
    input logic                clk,
    input logic                reset,
    input rob_pkg::rob_count_t count,
    input logic                alloc_ok,
    input rob_pkg::rob_idx_t   tail_idx,
    input logic                commit_ready_0,
    input logic                commit_ready_1,
    input logic                empty,
    input logic                full
);
    timeunit 1ns;
    timeprecision 100ps;

    count_in_range: assert property (@(posedge clk) disable iff (!reset)
        count <= rob_pkg::rob_count_t'(rob_pkg::rob_depth))
        else $error("occupancy above the buffer depth");

    // Head+1 only retires together with the head
    commit_in_order: assert property (@(posedge clk) disable iff (!reset)
        commit_ready_1 |-> commit_ready_0)
        else $error("second commit ready without the first");

    refused_alloc_holds_tail: assert property (@(posedge clk) disable iff (!reset)
        !alloc_ok |=> $stable(tail_idx))
        else $error("tail moved after a refused allocation");

    empty_full_exclusive: assert property (@(posedge clk) disable iff (!reset)
        !(empty && full))
        else $error("empty and full raised together");

endmodule

bind reorder_buffer reorder_buffer_sva u_sva (
    .clk            (clk),
    .reset          (reset),
    .count          (count),
    .alloc_ok       (alloc_ok),
    .tail_idx       (tail_idx),
    .commit_ready_0 (commit_ready_0),
    .commit_ready_1 (commit_ready_1),
    .empty          (empty),
    .full           (full)
);

//--- rtl/reorder_buffer.sv
module reorder_buffer (
    input  logic                            clk,
    input  logic                            reset,
    // Allocation
    input  logic [rob_pkg::alloc_slots-1:0] alloc_en,
    input  tag_pkg::tag_t                   alloc_tag_0,
    input  tag_pkg::tag_t                   alloc_tag_1,
    input  rob_pkg::dest_t                  alloc_dest_0,
    input  rob_pkg::dest_t                  alloc_dest_1,
    output logic                            alloc_ok,
    // Result bus
    input  logic [tag_pkg::cdb_lanes-1:0]   cdb_valid,
    input  rob_pkg::rob_idx_t               cdb_idx_0,
    input  rob_pkg::rob_idx_t               cdb_idx_1,
    input  rob_pkg::rob_data_t              cdb_data_0,
    input  rob_pkg::rob_data_t              cdb_data_1,
    input  logic [tag_pkg::cdb_lanes-1:0]   cdb_exc,
    // Reservation station reads
    input  rob_pkg::rob_idx_t               rd_idx_0,
    input  rob_pkg::rob_idx_t               rd_idx_1,
    output rob_pkg::rob_data_t              rd_data_0,
    output rob_pkg::rob_data_t              rd_data_1,
    output tag_pkg::tag_t                   rd_tag_0,
    output tag_pkg::tag_t                   rd_tag_1,
    // Commit
    output logic                            commit_ready_0,
    output logic                            commit_ready_1,
    output rob_pkg::rob_data_t              commit_data_0,
    output rob_pkg::rob_data_t              commit_data_1,
    output rob_pkg::dest_t                  commit_dest_0,
    output rob_pkg::dest_t                  commit_dest_1,
    output logic                            commit_exc_0,
    output logic                            commit_exc_1,
    // Status
    output rob_pkg::rob_count_t             count,
    output logic                            empty,
    output logic                            full,
    output rob_pkg::rob_idx_t               head_idx,
    output rob_pkg::rob_idx_t               tail_idx
);

    rob_pkg::rob_idx_t                alloc_idx_0;
    rob_pkg::rob_idx_t                alloc_idx_1;
    logic [1:0]                       commit_count;
    logic [tag_pkg::cdb_lanes-1:0]    cdb_hit;
    rob_pkg::rob_data_t               st_data_0;
    rob_pkg::rob_data_t               st_data_1;
    tag_pkg::tag_t                    st_tag_0;
    tag_pkg::tag_t                    st_tag_1;

    // ============================================================
    // Pointers and storage
    // ============================================================
    rob_pointers u_pointers (
        .clk          (clk),
        .reset        (reset),
        .alloc_en     (alloc_en),
        .commit_count (commit_count),
        .alloc_ok     (alloc_ok),
        .alloc_idx_0  (alloc_idx_0),
        .alloc_idx_1  (alloc_idx_1),
        .head_idx     (head_idx),
        .tail_idx     (tail_idx),
        .count        (count),
        .empty        (empty),
        .full         (full)
    );

    rob_entries u_entries (
        .clk            (clk),
        .reset          (reset),
        .alloc_ok       (alloc_ok),
        .alloc_en       (alloc_en),
        .alloc_idx_0    (alloc_idx_0),
        .alloc_idx_1    (alloc_idx_1),
        .alloc_tag_0    (alloc_tag_0),
        .alloc_tag_1    (alloc_tag_1),
        .alloc_dest_0   (alloc_dest_0),
        .alloc_dest_1   (alloc_dest_1),
        .cdb_valid      (cdb_valid),
        .cdb_idx_0      (cdb_idx_0),
        .cdb_idx_1      (cdb_idx_1),
        .cdb_data_0     (cdb_data_0),
        .cdb_data_1     (cdb_data_1),
        .cdb_exc        (cdb_exc),
        .cdb_hit        (cdb_hit),
        .head_idx       (head_idx),
        .count          (count),
        .commit_ready_0 (commit_ready_0),
        .commit_ready_1 (commit_ready_1),
        .commit_count   (commit_count),
        .commit_data_0  (commit_data_0),
        .commit_data_1  (commit_data_1),
        .commit_dest_0  (commit_dest_0),
        .commit_dest_1  (commit_dest_1),
        .commit_exc_0   (commit_exc_0),
        .commit_exc_1   (commit_exc_1),
        .rd_idx_0       (rd_idx_0),
        .rd_idx_1       (rd_idx_1),
        .st_data_0      (st_data_0),
        .st_data_1      (st_data_1),
        .st_tag_0       (st_tag_0),
        .st_tag_1       (st_tag_1)
    );

    // ============================================================
    // Forwarding read ports
    // ============================================================
    rob_read_port u_read_0 (
        .rd_idx      (rd_idx_0),
        .cdb_hit     (cdb_hit),
        .cdb_idx_0   (cdb_idx_0),
        .cdb_idx_1   (cdb_idx_1),
        .cdb_data_0  (cdb_data_0),
        .cdb_data_1  (cdb_data_1),
        .alloc_ok    (alloc_ok),
        .alloc_en    (alloc_en),
        .alloc_idx_0 (alloc_idx_0),
        .alloc_idx_1 (alloc_idx_1),
        .alloc_tag_0 (alloc_tag_0),
        .alloc_tag_1 (alloc_tag_1),
        .st_data     (st_data_0),
        .st_tag      (st_tag_0),
        .rd_data     (rd_data_0),
        .rd_tag      (rd_tag_0)
    );

    rob_read_port u_read_1 (
        .rd_idx      (rd_idx_1),
        .cdb_hit     (cdb_hit),
        .cdb_idx_0   (cdb_idx_0),
        .cdb_idx_1   (cdb_idx_1),
        .cdb_data_0  (cdb_data_0),
        .cdb_data_1  (cdb_data_1),
        .alloc_ok    (alloc_ok),
        .alloc_en    (alloc_en),
        .alloc_idx_0 (alloc_idx_0),
        .alloc_idx_1 (alloc_idx_1),
        .alloc_tag_0 (alloc_tag_0),
        .alloc_tag_1 (alloc_tag_1),
        .st_data     (st_data_1),
        .st_tag      (st_tag_1),
        .rd_data     (rd_data_1),
        .rd_tag      (rd_tag_1)
    );

endmodule

//--- rtl/rob_read_port.sv
module rob_read_port (
    input  rob_pkg::rob_idx_t               rd_idx,
    // Result bus, already tag checked
    input  logic [tag_pkg::cdb_lanes-1:0]   cdb_hit,
    input  rob_pkg::rob_idx_t               cdb_idx_0,
    input  rob_pkg::rob_idx_t               cdb_idx_1,
    input  rob_pkg::rob_data_t              cdb_data_0,
    input  rob_pkg::rob_data_t              cdb_data_1,
    // Same-cycle allocation
    input  logic                            alloc_ok,
    input  logic [rob_pkg::alloc_slots-1:0] alloc_en,
    input  rob_pkg::rob_idx_t               alloc_idx_0,
    input  rob_pkg::rob_idx_t               alloc_idx_1,
    input  tag_pkg::tag_t                   alloc_tag_0,
    input  tag_pkg::tag_t                   alloc_tag_1,
    // Stored entry
    input  rob_pkg::rob_data_t              st_data,
    input  tag_pkg::tag_t                   st_tag,
    output rob_pkg::rob_data_t              rd_data,
    output tag_pkg::tag_t                   rd_tag
);

    logic cdb_match_0;
    logic cdb_match_1;
    logic alloc_match_0;
    logic alloc_match_1;

    assign cdb_match_0   = cdb_hit[0] && (cdb_idx_0 == rd_idx);
    assign cdb_match_1   = cdb_hit[1] && (cdb_idx_1 == rd_idx);
    assign alloc_match_0 = alloc_ok && alloc_en[0] && (alloc_idx_0 == rd_idx);
    assign alloc_match_1 = alloc_ok && alloc_en[1] && (alloc_idx_1 == rd_idx);

    // Newest value first, same order as the storage writes
    always_comb begin
        if (cdb_match_1) begin
            rd_data = cdb_data_1;
            rd_tag  = tag_pkg::tag_ready;
        end else if (cdb_match_0) begin
            rd_data = cdb_data_0;
            rd_tag  = tag_pkg::tag_ready;
        end else if (alloc_match_1) begin
            rd_data = '0;           // Fresh entry, no result yet
            rd_tag  = alloc_tag_1;
        end else if (alloc_match_0) begin
            rd_data = '0;
            rd_tag  = alloc_tag_0;
        end else begin
            rd_data = st_data;
            rd_tag  = st_tag;
        end
    end

endmodule

//--- rtl/rob_entries.sv
module rob_entries (
    input  logic                            clk,
    input  logic                            reset,
    // Allocation
    input  logic                            alloc_ok,
    input  logic [rob_pkg::alloc_slots-1:0] alloc_en,
    input  rob_pkg::rob_idx_t               alloc_idx_0,
    input  rob_pkg::rob_idx_t               alloc_idx_1,
    input  tag_pkg::tag_t                   alloc_tag_0,
    input  tag_pkg::tag_t                   alloc_tag_1,
    input  rob_pkg::dest_t                  alloc_dest_0,
    input  rob_pkg::dest_t                  alloc_dest_1,
    // Result bus
    input  logic [tag_pkg::cdb_lanes-1:0]   cdb_valid,
    input  rob_pkg::rob_idx_t               cdb_idx_0,
    input  rob_pkg::rob_idx_t               cdb_idx_1,
    input  rob_pkg::rob_data_t              cdb_data_0,
    input  rob_pkg::rob_data_t              cdb_data_1,
    input  logic [tag_pkg::cdb_lanes-1:0]   cdb_exc,
    output logic [tag_pkg::cdb_lanes-1:0]   cdb_hit,
    // Commit
    input  rob_pkg::rob_idx_t               head_idx,
    input  rob_pkg::rob_count_t             count,
    output logic                            commit_ready_0,
    output logic                            commit_ready_1,
    output logic [1:0]                      commit_count,
    output rob_pkg::rob_data_t              commit_data_0,
    output rob_pkg::rob_data_t              commit_data_1,
    output rob_pkg::dest_t                  commit_dest_0,
    output rob_pkg::dest_t                  commit_dest_1,
    output logic                            commit_exc_0,
    output logic                            commit_exc_1,
    // Storage side of the read ports
    input  rob_pkg::rob_idx_t               rd_idx_0,
    input  rob_pkg::rob_idx_t               rd_idx_1,
    output rob_pkg::rob_data_t              st_data_0,
    output rob_pkg::rob_data_t              st_data_1,
    output tag_pkg::tag_t                   st_tag_0,
    output tag_pkg::tag_t                   st_tag_1
);

    rob_pkg::rob_data_t            ent_data [rob_pkg::rob_depth];
    tag_pkg::tag_t                 ent_tag  [rob_pkg::rob_depth];
    rob_pkg::dest_t                ent_dest [rob_pkg::rob_depth];
    logic [rob_pkg::rob_depth-1:0] ent_exec;
    logic [rob_pkg::rob_depth-1:0] ent_exc;

    rob_pkg::rob_idx_t  slot_idx  [rob_pkg::alloc_slots];
    tag_pkg::tag_t      slot_tag  [rob_pkg::alloc_slots];
    rob_pkg::dest_t     slot_dest [rob_pkg::alloc_slots];
    rob_pkg::rob_idx_t  lane_idx  [tag_pkg::cdb_lanes];
    rob_pkg::rob_data_t lane_data [tag_pkg::cdb_lanes];
    rob_pkg::rob_idx_t  commit_idx [rob_pkg::commit_slots];
    logic [rob_pkg::commit_slots-1:0] commit_rdy;

    assign slot_idx[0]  = alloc_idx_0;
    assign slot_idx[1]  = alloc_idx_1;
    assign slot_tag[0]  = alloc_tag_0;
    assign slot_tag[1]  = alloc_tag_1;
    assign slot_dest[0] = alloc_dest_0;
    assign slot_dest[1] = alloc_dest_1;
    assign lane_idx[0]  = cdb_idx_0;
    assign lane_idx[1]  = cdb_idx_1;
    assign lane_data[0] = cdb_data_0;
    assign lane_data[1] = cdb_data_1;

    // ============================================================
    // Result acceptance and commit readiness
    // ============================================================
    always_comb begin
        for (int k = 0; k < tag_pkg::cdb_lanes; k++) begin
            cdb_hit[k] = cdb_valid[k] && (ent_tag[lane_idx[k]] == tag_pkg::tag_t'(k));
        end
        for (int i = 0; i < rob_pkg::commit_slots; i++) begin
            commit_idx[i] = head_idx + rob_pkg::rob_idx_t'(i);
        end
    end

    // In order only, head+1 never retires without the head
    assign commit_rdy[0] = (count != '0) && ent_exec[commit_idx[0]];
    assign commit_rdy[1] = commit_rdy[0] && (count >= rob_pkg::rob_count_t'(2))
                           && ent_exec[commit_idx[1]];

    assign commit_ready_0 = commit_rdy[0];
    assign commit_ready_1 = commit_rdy[1];
    assign commit_count   = 2'(commit_rdy[0]) + 2'(commit_rdy[1]);

    assign commit_data_0 = ent_data[commit_idx[0]];
    assign commit_data_1 = ent_data[commit_idx[1]];
    assign commit_dest_0 = ent_dest[commit_idx[0]];
    assign commit_dest_1 = ent_dest[commit_idx[1]];
    assign commit_exc_0  = ent_exc[commit_idx[0]];
    assign commit_exc_1  = ent_exc[commit_idx[1]];

    assign st_data_0 = ent_data[rd_idx_0];
    assign st_data_1 = ent_data[rd_idx_1];
    assign st_tag_0  = ent_tag[rd_idx_0];
    assign st_tag_1  = ent_tag[rd_idx_1];

    // ============================================================
    // Entry updates
    // ============================================================
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < rob_pkg::rob_depth; i++) begin
                ent_data[i] <= '0;
                ent_tag[i]  <= tag_pkg::tag_free;
                ent_dest[i] <= '0;
                ent_exec[i] <= 1'b0;
                ent_exc[i]  <= 1'b0;
            end
        end else begin
            for (int s = 0; s < rob_pkg::alloc_slots; s++) begin
                if (alloc_ok && alloc_en[s]) begin
                    ent_data[slot_idx[s]] <= '0;  // Result not produced yet
                    ent_tag[slot_idx[s]]  <= slot_tag[s];
                    ent_dest[slot_idx[s]] <= slot_dest[s];
                    ent_exec[slot_idx[s]] <= 1'b0;
                    ent_exc[slot_idx[s]]  <= 1'b0;
                end
            end
            // Later lane overrides, so lane 1 wins on a shared index
            for (int k = 0; k < tag_pkg::cdb_lanes; k++) begin
                if (cdb_hit[k]) begin
                    ent_data[lane_idx[k]] <= lane_data[k];
                    ent_tag[lane_idx[k]]  <= tag_pkg::tag_ready;
                    ent_exec[lane_idx[k]] <= 1'b1;
                    ent_exc[lane_idx[k]]  <= cdb_exc[k];
                end
            end
            // Retired entries go back to the free state with the head move
            for (int i = 0; i < rob_pkg::commit_slots; i++) begin
                if (commit_rdy[i]) begin
                    ent_data[commit_idx[i]] <= '0;
                    ent_tag[commit_idx[i]]  <= tag_pkg::tag_free;
                    ent_dest[commit_idx[i]] <= '0;
                    ent_exec[commit_idx[i]] <= 1'b0;
                    ent_exc[commit_idx[i]]  <= 1'b0;
                end
            end
        end
    end

endmodule

//--- rtl/rob_pointers.sv
module rob_pointers (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [rob_pkg::alloc_slots-1:0] alloc_en,
    input  logic [1:0]                      commit_count,
    output logic                            alloc_ok,
    output rob_pkg::rob_idx_t               alloc_idx_0,
    output rob_pkg::rob_idx_t               alloc_idx_1,
    output rob_pkg::rob_idx_t               head_idx,
    output rob_pkg::rob_idx_t               tail_idx,
    output rob_pkg::rob_count_t             count,
    output logic                            empty,
    output logic                            full
);

    rob_pkg::rob_ptr_t   head_ptr;
    rob_pkg::rob_ptr_t   tail_ptr;
    rob_pkg::rob_count_t free_slots;
    logic [1:0]          alloc_count;

    // ============================================================
    // Occupancy
    // ============================================================
    // Wrap bit keeps the difference right when tail has lapped head
    assign count      = tail_ptr - head_ptr;
    assign free_slots = rob_pkg::rob_count_t'(rob_pkg::rob_depth) - count;
    assign empty      = (count == '0);
    assign full       = (count == rob_pkg::rob_count_t'(rob_pkg::rob_depth));

    assign head_idx = head_ptr[rob_pkg::rob_idx_w-1:0];
    assign tail_idx = tail_ptr[rob_pkg::rob_idx_w-1:0];

    // ============================================================
    // Allocation decision
    // ============================================================
    always_comb begin
        alloc_count = '0;
        for (int i = 0; i < rob_pkg::alloc_slots; i++) begin
            alloc_count = alloc_count + 2'(alloc_en[i]);
        end
    end

    // All requested slots fit, or none is taken
    assign alloc_ok = (free_slots >= rob_pkg::rob_count_t'(alloc_count));

    assign alloc_idx_0 = tail_idx;
    assign alloc_idx_1 = tail_idx + rob_pkg::rob_idx_t'(alloc_en[0]);  // Packs behind slot 0

    // Head moves by commits, tail by accepted allocations
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            head_ptr <= '0;
            tail_ptr <= '0;
        end else begin
            head_ptr <= head_ptr + rob_pkg::rob_ptr_t'(commit_count);
            if (alloc_ok) begin
                tail_ptr <= tail_ptr + rob_pkg::rob_ptr_t'(alloc_count);
            end
        end
    end

endmodule

//--- rtl/tag_pkg.sv
package tag_pkg;

    // ============================================================
    // Producer tags and result bus
    // ============================================================
    localparam int tag_w     = 3;
    localparam int cdb_lanes = 2;

    typedef logic [tag_w-1:0] tag_t;

    // Lane k produces tag k, so tags 0 .. cdb_lanes-1 name a pending producer
    localparam tag_t tag_ready = '1;  // Result present in the entry
    localparam tag_t tag_free  = '0;  // Entry cleared

endpackage

//--- rtl/rob_pkg.sv
package rob_pkg;

    // ============================================================
    // Buffer geometry
    // ============================================================
    localparam int rob_depth    = 16;
    localparam int rob_idx_w    = 4;
    localparam int alloc_slots  = 2;   // Allocations per cycle
    localparam int commit_slots = 2;   // Commits per cycle

    typedef logic [rob_idx_w-1:0] rob_idx_t;
    typedef logic [rob_idx_w:0]   rob_ptr_t;    // Index plus wrap bit
    typedef logic [rob_idx_w:0]   rob_count_t;  // Occupancy, 0 to rob_depth

    // ============================================================
    // Entry and commit fields
    // ============================================================
    localparam int data_w = 32;

    typedef logic [data_w-1:0] rob_data_t;  // Result value
    typedef logic [4:0]        dest_t;      // Architectural destination register

endpackage
